/* hdl/axi_pkg.sv */
package axi_pkg;

   // bus geometry of the single memory port
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;

   // burst type, only INCR is served by the sram
   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_e;

   // response codes
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // arsize/awsize code for full 8-byte beats
   localparam logic [2:0] SIZE_8B = 3'd3;

endpackage

/* hdl/lsu_pkg.sv */
package lsu_pkg;

   // load/store opcode from the core
   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_op_e;

   // read channel owner in the arbiter
   typedef enum logic [1:0] {
      ARB_IDLE  = 2'b00,
      ARB_FETCH = 2'b01,
      ARB_LSU   = 2'b10
   } arb_state_e;

   // byte offset bits inside one 64-bit beat,
   // the line offset adds log2 of the beat count on top
   localparam int BEAT_OFFS_W = 3;

endpackage

/* hdl/axi_if.sv */
`timescale 1ns/1ns

interface axi_if import axi_pkg::*; ();

   // read address
   logic [ADDR_W-1:0] araddr;
   logic [7:0]        arlen;
   logic [2:0]        arsize;
   axi_burst_e        arburst;
   logic              arvalid;
   logic              arready;

   // read data
   logic [DATA_W-1:0] rdata;
   axi_resp_e         rresp;
   logic              rlast;
   logic              rvalid;
   logic              rready;

   // write address
   logic [ADDR_W-1:0] awaddr;
   logic [7:0]        awlen;
   logic [2:0]        awsize;
   axi_burst_e        awburst;
   logic              awvalid;
   logic              awready;

   // write data
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic              wlast;
   logic              wvalid;
   logic              wready;

   // write response
   axi_resp_e         bresp;
   logic              bvalid;
   logic              bready;

   modport master (
      output araddr, arlen, arsize, arburst, arvalid, input arready,
      input rdata, rresp, rlast, rvalid, output rready,
      output awaddr, awlen, awsize, awburst, awvalid, input awready,
      output wdata, wstrb, wlast, wvalid, input wready,
      input bresp, bvalid, output bready
   );

   modport slave (
      input araddr, arlen, arsize, arburst, arvalid, output arready,
      output rdata, rresp, rlast, rvalid, input rready,
      input awaddr, awlen, awsize, awburst, awvalid, output awready,
      input wdata, wstrb, wlast, wvalid, output wready,
      output bresp, bvalid, input bready
   );

endinterface

/* hdl/axi_arbiter.sv */
`timescale 1ns/1ns

module axi_arbiter import axi_pkg::*, lsu_pkg::*; (
   input logic   clk,
   input logic   rst,
   axi_if.slave  fetch_bus,
   axi_if.slave  lsu_bus,
   axi_if.master mem_bus
);

   arb_state_e state;
   arb_state_e state_nxt;
   logic       idle;
   logic       sel_fetch;
   logic       ar_fire;
   logic       r_last_fire;

   assign idle = (state == ARB_IDLE);

   // fetch wins when both masters are valid
   assign sel_fetch   = fetch_bus.arvalid;
   assign ar_fire     = mem_bus.arvalid && mem_bus.arready;
   assign r_last_fire = mem_bus.rvalid && mem_bus.rready && mem_bus.rlast;

   always_comb begin
      state_nxt = state;
      case (state)
         ARB_IDLE: begin
            // grant only once the address is actually taken
            if (ar_fire) begin
               state_nxt = sel_fetch ? ARB_FETCH : ARB_LSU;
            end
         end
         ARB_FETCH, ARB_LSU: begin
            if (r_last_fire) begin
               state_nxt = ARB_IDLE;
            end
         end
         default: begin
            state_nxt = ARB_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ARB_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // address channel, muxed straight through while idle
   assign mem_bus.arvalid = idle && (fetch_bus.arvalid || lsu_bus.arvalid);
   assign mem_bus.araddr  = sel_fetch ? fetch_bus.araddr  : lsu_bus.araddr;
   assign mem_bus.arlen   = sel_fetch ? fetch_bus.arlen   : lsu_bus.arlen;
   assign mem_bus.arsize  = sel_fetch ? fetch_bus.arsize  : lsu_bus.arsize;
   assign mem_bus.arburst = sel_fetch ? fetch_bus.arburst : lsu_bus.arburst;

   // arready only to the master being forwarded
   assign fetch_bus.arready = idle && sel_fetch && mem_bus.arready;
   assign lsu_bus.arready   = idle && !sel_fetch && mem_bus.arready;

   // data channel to the owner, zeros to the other
   assign fetch_bus.rdata  = (state == ARB_FETCH) ? mem_bus.rdata  : '0;
   assign fetch_bus.rresp  = (state == ARB_FETCH) ? mem_bus.rresp  : OKAY;
   assign fetch_bus.rlast  = (state == ARB_FETCH) && mem_bus.rlast;
   assign fetch_bus.rvalid = (state == ARB_FETCH) && mem_bus.rvalid;
   assign lsu_bus.rdata    = (state == ARB_LSU) ? mem_bus.rdata  : '0;
   assign lsu_bus.rresp    = (state == ARB_LSU) ? mem_bus.rresp  : OKAY;
   assign lsu_bus.rlast    = (state == ARB_LSU) && mem_bus.rlast;
   assign lsu_bus.rvalid   = (state == ARB_LSU) && mem_bus.rvalid;

   // rready from whoever owns the burst
   assign mem_bus.rready = (state == ARB_FETCH) ? fetch_bus.rready :
                           (state == ARB_LSU)   ? lsu_bus.rready   : 1'b0;

   // write side belongs to the lsu alone
   assign mem_bus.awaddr  = lsu_bus.awaddr;
   assign mem_bus.awlen   = lsu_bus.awlen;
   assign mem_bus.awsize  = lsu_bus.awsize;
   assign mem_bus.awburst = lsu_bus.awburst;
   assign mem_bus.awvalid = lsu_bus.awvalid;
   assign lsu_bus.awready = mem_bus.awready;

   assign mem_bus.wdata  = lsu_bus.wdata;
   assign mem_bus.wstrb  = lsu_bus.wstrb;
   assign mem_bus.wlast  = lsu_bus.wlast;
   assign mem_bus.wvalid = lsu_bus.wvalid;
   assign lsu_bus.wready = mem_bus.wready;

   assign lsu_bus.bresp  = mem_bus.bresp;
   assign lsu_bus.bvalid = mem_bus.bvalid;
   assign mem_bus.bready = lsu_bus.bready;

   // fetch has no write path
   assign fetch_bus.awready = 1'b0;
   assign fetch_bus.wready  = 1'b0;
   assign fetch_bus.bvalid  = 1'b0;
   assign fetch_bus.bresp   = OKAY;

endmodule

/* hdl/fetch_master.sv */
`timescale 1ns/1ns

module fetch_master import axi_pkg::*, lsu_pkg::*; #(
   parameter int LINE_BEATS = 4
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         fetch_req,
   input  logic [ADDR_W-1:0]            fetch_addr,
   output logic [LINE_BEATS*DATA_W-1:0] fetch_line,
   output logic                         fetch_done,
   output logic                         fetch_busy,
   output logic                         fetch_err,
   axi_if.master                        bus
);

   // byte offset bits of a whole line
   localparam int LINE_OFFS_W = BEAT_OFFS_W + $clog2(LINE_BEATS);

   logic              ar_pend;
   logic [ADDR_W-1:0] line_addr;
   logic              beat_fire;

   assign beat_fire = bus.rvalid && bus.rready;

   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_busy <= 1'b0;
         ar_pend    <= 1'b0;
         fetch_done <= 1'b0;
         fetch_err  <= 1'b0;
      end else begin
         fetch_done <= 1'b0;
         if (fetch_req && !fetch_busy) begin
            fetch_busy <= 1'b1;
            ar_pend    <= 1'b1;
            fetch_err  <= 1'b0;
         end
         if (bus.arvalid && bus.arready) begin
            ar_pend <= 1'b0;
         end
         if (beat_fire) begin
            // sticky over the whole line
            if (bus.rresp != OKAY) begin
               fetch_err <= 1'b1;
            end
            if (bus.rlast) begin
               fetch_busy <= 1'b0;
               fetch_done <= 1'b1;
            end
         end
      end
   end

   // line base and assembled beats, payload only
   always_ff @(posedge clk) begin
      if (fetch_req && !fetch_busy) begin
         line_addr <= {fetch_addr[ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
      end
      if (beat_fire) begin
         // first beat ends up in slice 0
         fetch_line <= {bus.rdata, fetch_line[LINE_BEATS*DATA_W-1:DATA_W]};
      end
   end

   assign bus.araddr  = line_addr;
   assign bus.arlen   = 8'(LINE_BEATS - 1);
   assign bus.arsize  = SIZE_8B;
   assign bus.arburst = INCR;
   assign bus.arvalid = ar_pend;
   assign bus.rready  = fetch_busy;

   // read-only master
   assign bus.awaddr  = '0;
   assign bus.awlen   = '0;
   assign bus.awsize  = SIZE_8B;
   assign bus.awburst = INCR;
   assign bus.awvalid = 1'b0;
   assign bus.wdata   = '0;
   assign bus.wstrb   = '0;
   assign bus.wlast   = 1'b0;
   assign bus.wvalid  = 1'b0;
   assign bus.bready  = 1'b0;

endmodule

/* hdl/lsu_master.sv */
`timescale 1ns/1ns

module lsu_master import axi_pkg::*, lsu_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              lsu_req,
   input  lsu_op_e           lsu_op,
   input  logic [ADDR_W-1:0] lsu_addr,
   input  logic [DATA_W-1:0] lsu_wdata,
   input  logic [STRB_W-1:0] lsu_wstrb,
   output logic [DATA_W-1:0] lsu_rdata,
   output axi_resp_e         lsu_resp,
   output logic              lsu_done,
   output logic              lsu_busy,
   axi_if.master             bus
);

   typedef enum logic [2:0] {
      L_IDLE,
      L_ADDR,
      L_DATA,
      L_RESP,
      L_FINISH
   } lsu_state_e;

   lsu_state_e        state;
   lsu_op_e           op_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] wstrb_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= L_IDLE;
      end else begin
         case (state)
            L_IDLE: begin
               if (lsu_req) begin
                  state <= L_ADDR;
               end
            end
            L_ADDR: begin
               // load waits on ar, store on aw
               if ((bus.arvalid && bus.arready) || (bus.awvalid && bus.awready)) begin
                  state <= L_DATA;
               end
            end
            L_DATA: begin
               if (bus.rvalid && bus.rready) begin
                  state <= L_FINISH;
               end else if (bus.wvalid && bus.wready) begin
                  state <= L_RESP;
               end
            end
            L_RESP: begin
               if (bus.bvalid && bus.bready) begin
                  state <= L_FINISH;
               end
            end
            default: begin
               state <= L_IDLE;
            end
         endcase
      end
   end

   // request fields and results
   always_ff @(posedge clk) begin
      if (state == L_IDLE && lsu_req) begin
         op_q    <= lsu_op;
         addr_q  <= lsu_addr;
         wdata_q <= lsu_wdata;
         wstrb_q <= lsu_wstrb;
      end
      if (bus.rvalid && bus.rready) begin
         lsu_rdata <= bus.rdata;
         lsu_resp  <= bus.rresp;
      end
      if (bus.bvalid && bus.bready) begin
         lsu_resp <= bus.bresp;
      end
   end

   assign lsu_done = (state == L_FINISH);
   assign lsu_busy = (state != L_IDLE);

   // single-beat read
   assign bus.araddr  = addr_q;
   assign bus.arlen   = 8'd0;
   assign bus.arsize  = SIZE_8B;
   assign bus.arburst = INCR;
   assign bus.arvalid = (state == L_ADDR) && (op_q == LSU_LOAD);
   assign bus.rready  = (state == L_DATA) && (op_q == LSU_LOAD);

   // single-beat write
   assign bus.awaddr  = addr_q;
   assign bus.awlen   = 8'd0;
   assign bus.awsize  = SIZE_8B;
   assign bus.awburst = INCR;
   assign bus.awvalid = (state == L_ADDR) && (op_q == LSU_STORE);
   assign bus.wdata   = wdata_q;
   assign bus.wstrb   = wstrb_q;
   assign bus.wlast   = 1'b1;
   assign bus.wvalid  = (state == L_DATA) && (op_q == LSU_STORE);
   assign bus.bready  = (state == L_RESP);

endmodule

/* hdl/axi_sram.sv */
`timescale 1ns/1ns

module axi_sram import axi_pkg::*; #(
   parameter int MEM_WORDS = 1024
) (
   input logic  clk,
   input logic  rst,
   axi_if.slave bus
);

   localparam int OFFS_W = $clog2(STRB_W);
   localparam int WIDX_W = ADDR_W - OFFS_W;
   localparam int MEM_AW = $clog2(MEM_WORDS);

   typedef enum logic [1:0] {
      W_IDLE,
      W_DATA,
      W_RESP
   } wr_state_e;

   logic [DATA_W-1:0] mem [MEM_WORDS];

   // read engine
   logic              rd_active;
   logic [WIDX_W-1:0] rd_idx;
   logic [7:0]        rd_cnt;
   logic              rd_ok;

   // write engine
   wr_state_e         wr_state;
   logic [WIDX_W-1:0] wr_idx;
   logic              wr_err;
   logic              wr_ok;

   assign rd_ok = (rd_idx < WIDX_W'(MEM_WORDS));
   assign wr_ok = (wr_idx < WIDX_W'(MEM_WORDS));

   // burst type ignored, every burst walks upward
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_active <= 1'b0;
      end else if (bus.arvalid && bus.arready) begin
         rd_active <= 1'b1;
         rd_idx    <= bus.araddr[ADDR_W-1:OFFS_W];
         rd_cnt    <= bus.arlen;
      end else if (bus.rvalid && bus.rready) begin
         if (bus.rlast) begin
            rd_active <= 1'b0;
         end else begin
            rd_idx <= rd_idx + 1'b1;
            rd_cnt <= rd_cnt - 1'b1;
         end
      end
   end

   assign bus.arready = !rd_active;
   assign bus.rvalid  = rd_active;
   assign bus.rlast   = (rd_cnt == 8'd0);
   // out of range reads give zeros
   assign bus.rdata   = rd_ok ? mem[rd_idx[MEM_AW-1:0]] : '0;
   assign bus.rresp   = rd_ok ? OKAY : SLVERR;

   // aw, then w beats until wlast, then b
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_state <= W_IDLE;
         wr_err   <= 1'b0;
      end else begin
         case (wr_state)
            W_IDLE: begin
               if (bus.awvalid) begin
                  wr_state <= W_DATA;
                  wr_idx   <= bus.awaddr[ADDR_W-1:OFFS_W];
                  wr_err   <= 1'b0;
               end
            end
            W_DATA: begin
               if (bus.wvalid) begin
                  wr_idx <= wr_idx + 1'b1;
                  if (!wr_ok) begin
                     wr_err <= 1'b1;
                  end
                  if (bus.wlast) begin
                     wr_state <= W_RESP;
                  end
               end
            end
            W_RESP: begin
               if (bus.bready) begin
                  wr_state <= W_IDLE;
               end
            end
            default: begin
               wr_state <= W_IDLE;
            end
         endcase
      end
   end

   // byte lanes, dropped when out of range
   always_ff @(posedge clk) begin
      if (bus.wvalid && bus.wready && wr_ok) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (bus.wstrb[b]) begin
               mem[wr_idx[MEM_AW-1:0]][b*8 +: 8] <= bus.wdata[b*8 +: 8];
            end
         end
      end
   end

   assign bus.awready = (wr_state == W_IDLE);
   assign bus.wready  = (wr_state == W_DATA);
   assign bus.bvalid  = (wr_state == W_RESP);
   assign bus.bresp   = wr_err ? SLVERR : OKAY;

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top import axi_pkg::*, lsu_pkg::*; #(
   parameter int LINE_BEATS = 4,
   parameter int MEM_WORDS  = 1024
) (
   input  logic                         clk,
   input  logic                         rst,
   // instruction fetch side
   input  logic                         fetch_req,
   input  logic [ADDR_W-1:0]            fetch_addr,
   output logic [LINE_BEATS*DATA_W-1:0] fetch_line,
   output logic                         fetch_done,
   output logic                         fetch_busy,
   output logic                         fetch_err,
   // load/store side
   input  logic                         lsu_req,
   input  lsu_op_e                      lsu_op,
   input  logic [ADDR_W-1:0]            lsu_addr,
   input  logic [DATA_W-1:0]            lsu_wdata,
   input  logic [STRB_W-1:0]            lsu_wstrb,
   output logic [DATA_W-1:0]            lsu_rdata,
   output axi_resp_e                    lsu_resp,
   output logic                         lsu_done,
   output logic                         lsu_busy
);

   axi_if fetch_bus ();
   axi_if lsu_bus ();
   axi_if mem_bus ();

   fetch_master #(
      .LINE_BEATS (LINE_BEATS)
   ) i_fetch (
      .clk        (clk),
      .rst        (rst),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .fetch_line (fetch_line),
      .fetch_done (fetch_done),
      .fetch_busy (fetch_busy),
      .fetch_err  (fetch_err),
      .bus        (fetch_bus.master)
   );

   lsu_master i_lsu (
      .clk       (clk),
      .rst       (rst),
      .lsu_req   (lsu_req),
      .lsu_op    (lsu_op),
      .lsu_addr  (lsu_addr),
      .lsu_wdata (lsu_wdata),
      .lsu_wstrb (lsu_wstrb),
      .lsu_rdata (lsu_rdata),
      .lsu_resp  (lsu_resp),
      .lsu_done  (lsu_done),
      .lsu_busy  (lsu_busy),
      .bus       (lsu_bus.master)
   );

   // one shared port toward the sram
   axi_arbiter i_arb (
      .clk       (clk),
      .rst       (rst),
      .fetch_bus (fetch_bus.slave),
      .lsu_bus   (lsu_bus.slave),
      .mem_bus   (mem_bus.master)
   );

   axi_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) i_sram (
      .clk (clk),
      .rst (rst),
      .bus (mem_bus.slave)
   );

endmodule

/* sim/mem_subsys_sva.sv */
`timescale 1ns/1ns

module arb_sva import axi_pkg::*, lsu_pkg::*; (
   input logic              clk,
   input logic              rst,
   input arb_state_e        state,
   input logic              fetch_arvalid,
   input logic              fetch_arready,
   input logic              lsu_arvalid,
   input logic              lsu_arready,
   input logic [ADDR_W-1:0] lsu_araddr,
   input logic              fetch_rvalid,
   input logic              lsu_rvalid,
   input logic              mem_rvalid,
   input logic              mem_rready,
   input logic              mem_rlast
);

   arb_state_e owner;

   // burst owner as seen from the handshakes on the ports
   always_ff @(posedge clk) begin
      if (rst) begin
         owner <= ARB_IDLE;
      end else if (fetch_arvalid && fetch_arready) begin
         owner <= ARB_FETCH;
      end else if (lsu_arvalid && lsu_arready) begin
         owner <= ARB_LSU;
      end else if (mem_rvalid && mem_rready && mem_rlast) begin
         owner <= ARB_IDLE;
      end
   end

   // no address accepted while a burst is owned
   a_busy_no_arready: assert property (@(posedge clk) disable iff (rst)
      owner != ARB_IDLE |-> !fetch_arready && !lsu_arready)
      else $error("arready given while a burst is outstanding");

   // data only to the owner
   a_fetch_rvalid: assert property (@(posedge clk) disable iff (rst)
      owner != ARB_FETCH |-> !fetch_rvalid)
      else $error("fetch master sees rvalid without owning the burst");

   a_lsu_rvalid: assert property (@(posedge clk) disable iff (rst)
      owner != ARB_LSU |-> !lsu_rvalid)
      else $error("lsu master sees rvalid without owning the burst");

   // losing request held until taken
   a_ar_stable: assert property (@(posedge clk) disable iff (rst)
      lsu_arvalid && !lsu_arready |=> lsu_arvalid && $stable(lsu_araddr))
      else $error("lsu read address dropped or changed before arready");

   // grant state follows the handshakes, idle again after the last beat
   a_state_owner: assert property (@(posedge clk) disable iff (rst)
      state == owner)
      else $error("arbiter state does not match the burst owner");

endmodule

bind axi_arbiter arb_sva i_arb_sva (
   .clk           (clk),
   .rst           (rst),
   .state         (state),
   .fetch_arvalid (fetch_bus.arvalid),
   .fetch_arready (fetch_bus.arready),
   .lsu_arvalid   (lsu_bus.arvalid),
   .lsu_arready   (lsu_bus.arready),
   .lsu_araddr    (lsu_bus.araddr),
   .fetch_rvalid  (fetch_bus.rvalid),
   .lsu_rvalid    (lsu_bus.rvalid),
   .mem_rvalid    (mem_bus.rvalid),
   .mem_rready    (mem_bus.rready),
   .mem_rlast     (mem_bus.rlast)
);

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ns

module tb_mem_subsys import axi_pkg::*, lsu_pkg::*; ();

   localparam int LINE_BEATS   = 4;
   localparam int MEM_WORDS    = 1024;
   localparam int LINE_BYTES   = LINE_BEATS * 8;
   // words written by the fill, all tests stay inside them
   localparam int REGION_WORDS = 128;
   localparam int OOR_BASE     = MEM_WORDS * 8;
   // tests take roughly 2100 cycles
   localparam int MAX_CYCLES   = 4000;

   logic                         clk;
   logic                         rst;
   logic                         fetch_req;
   logic [ADDR_W-1:0]            fetch_addr;
   logic [LINE_BEATS*DATA_W-1:0] fetch_line;
   logic                         fetch_done;
   logic                         fetch_busy;
   logic                         fetch_err;
   logic                         lsu_req;
   lsu_op_e                      lsu_op;
   logic [ADDR_W-1:0]            lsu_addr;
   logic [DATA_W-1:0]            lsu_wdata;
   logic [STRB_W-1:0]            lsu_wstrb;
   logic [DATA_W-1:0]            lsu_rdata;
   axi_resp_e                    lsu_resp;
   logic                         lsu_done;
   logic                         lsu_busy;

   // reference memory, keyed by word index
   logic [DATA_W-1:0] ref_mem [int unsigned];

   // outstanding requests, oldest first
   logic [ADDR_W-1:0] lsu_addr_q [$];
   logic              lsu_load_q [$];
   logic [ADDR_W-1:0] fetch_base_q [$];

   int    seed = 32'h5ccc;
   string cur_test;
   int    cycle = 0;
   int    checks = 0;
   int    errors = 0;
   int    test_errs = 0;
   int    tests_run = 0;
   int    tests_bad = 0;
   int    lsu_done_cnt = 0;
   int    fetch_done_cnt = 0;
   int    lsu_done_cyc = 0;
   int    fetch_done_cyc = 0;

   mem_subsys_top #(
      .LINE_BEATS (LINE_BEATS),
      .MEM_WORDS  (MEM_WORDS)
   ) i_dut (
      .clk        (clk),
      .rst        (rst),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .fetch_line (fetch_line),
      .fetch_done (fetch_done),
      .fetch_busy (fetch_busy),
      .fetch_err  (fetch_err),
      .lsu_req    (lsu_req),
      .lsu_op     (lsu_op),
      .lsu_addr   (lsu_addr),
      .lsu_wdata  (lsu_wdata),
      .lsu_wstrb  (lsu_wstrb),
      .lsu_rdata  (lsu_rdata),
      .lsu_resp   (lsu_resp),
      .lsu_done   (lsu_done),
      .lsu_busy   (lsu_busy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // cycle count and hard stop
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("timeout, run still busy after %0d cycles", cycle);
         $display("tests failed");
         $finish;
      end
   end

   // word at addr, zero when out of range or never written
   function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
      int unsigned idx;
      idx = addr >> 3;
      if (idx >= MEM_WORDS || !ref_mem.exists(idx)) begin
         return '0;
      end
      return ref_mem[idx];
   endfunction

   function automatic axi_resp_e ref_resp(input logic [ADDR_W-1:0] addr);
      int unsigned idx;
      idx = addr >> 3;
      return (idx < MEM_WORDS) ? OKAY : SLVERR;
   endfunction

   // a line is in error if any of its beats is
   function automatic logic ref_line_err(input logic [ADDR_W-1:0] base);
      logic err;
      int   i;
      err = 1'b0;
      for (i = 0; i < LINE_BEATS; i++) begin
         if (ref_resp(base + ADDR_W'(i * 8)) != OKAY) begin
            err = 1'b1;
         end
      end
      return err;
   endfunction

   // byte-wise merge, writes out of range are dropped
   task automatic ref_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
      int unsigned       idx;
      logic [DATA_W-1:0] word;
      int                b;
      idx = addr >> 3;
      if (idx < MEM_WORDS) begin
         word = ref_read(addr);
         for (b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
               word[b*8 +: 8] = data[b*8 +: 8];
            end
         end
         ref_mem[idx] = word;
      end
   endtask

   task automatic report_mismatch(input string what, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
      $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
   endtask

   // busy level sampled at mid-cycle
   task automatic check_busy(input string what, input logic act, input logic exp);
      checks++;
      if (act !== exp) begin
         report_mismatch(what, DATA_W'(exp), DATA_W'(act));
      end
   endtask

   // compare at mid-cycle, outputs are settled by then
   always @(negedge clk) begin : compare
      logic [ADDR_W-1:0] addr;
      logic              is_load;
      int                i;
      if (!rst && lsu_done) begin
         if (lsu_addr_q.size() == 0) begin
            $display("%s: lsu_done pulsed with no request outstanding", cur_test);
            errors++;
         end else begin
            addr    = lsu_addr_q.pop_front();
            is_load = lsu_load_q.pop_front();
            checks++;
            if (lsu_resp !== ref_resp(addr)) begin
               report_mismatch("lsu_resp", DATA_W'(ref_resp(addr)), DATA_W'(lsu_resp));
            end
            if (is_load) begin
               checks++;
               if (lsu_rdata !== ref_read(addr)) begin
                  report_mismatch("lsu_rdata", ref_read(addr), lsu_rdata);
               end
            end
         end
         lsu_done_cnt++;
         lsu_done_cyc = cycle;
      end
      if (!rst && fetch_done) begin
         if (fetch_base_q.size() == 0) begin
            $display("%s: fetch_done pulsed with no request outstanding", cur_test);
            errors++;
         end else begin
            addr = fetch_base_q.pop_front();
            checks++;
            if (fetch_err !== ref_line_err(addr)) begin
               report_mismatch("fetch_err", DATA_W'(ref_line_err(addr)), DATA_W'(fetch_err));
            end
            // slice i holds the beat at base + 8*i
            for (i = 0; i < LINE_BEATS; i++) begin
               checks++;
               if (fetch_line[i*DATA_W +: DATA_W] !== ref_read(addr + ADDR_W'(i * 8))) begin
                  report_mismatch($sformatf("fetch_line slice %0d", i),
                                  ref_read(addr + ADDR_W'(i * 8)),
                                  fetch_line[i*DATA_W +: DATA_W]);
               end
            end
         end
         fetch_done_cnt++;
         fetch_done_cyc = cycle;
      end
   end

   task automatic issue_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
      int start;
      start = lsu_done_cnt;
      lsu_addr_q.push_back(addr);
      lsu_load_q.push_back(1'b0);
      ref_write(addr, data, strb);
      @(posedge clk);
      lsu_req   <= 1'b1;
      lsu_op    <= LSU_STORE;
      lsu_addr  <= addr;
      lsu_wdata <= data;
      lsu_wstrb <= strb;
      @(posedge clk);
      lsu_req <= 1'b0;
      @(negedge clk);
      check_busy("lsu_busy", lsu_busy, 1'b1);
      while (lsu_done_cnt == start) @(posedge clk);
      @(negedge clk);
      check_busy("lsu_busy", lsu_busy, 1'b0);
   endtask

   task automatic issue_load(input logic [ADDR_W-1:0] addr);
      int start;
      start = lsu_done_cnt;
      lsu_addr_q.push_back(addr);
      lsu_load_q.push_back(1'b1);
      @(posedge clk);
      lsu_req  <= 1'b1;
      lsu_op   <= LSU_LOAD;
      lsu_addr <= addr;
      @(posedge clk);
      lsu_req <= 1'b0;
      @(negedge clk);
      check_busy("lsu_busy", lsu_busy, 1'b1);
      while (lsu_done_cnt == start) @(posedge clk);
      @(negedge clk);
      check_busy("lsu_busy", lsu_busy, 1'b0);
   endtask

   task automatic issue_fetch(input logic [ADDR_W-1:0] addr);
      int start;
      start = fetch_done_cnt;
      fetch_base_q.push_back(addr & ~ADDR_W'(LINE_BYTES - 1));
      @(posedge clk);
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
      @(posedge clk);
      fetch_req <= 1'b0;
      @(negedge clk);
      check_busy("fetch_busy", fetch_busy, 1'b1);
      while (fetch_done_cnt == start) @(posedge clk);
      @(negedge clk);
      check_busy("fetch_busy", fetch_busy, 1'b0);
   endtask

   // both requests on one edge, fetch has to finish first
   task automatic issue_both(input logic [ADDR_W-1:0] faddr, input logic [ADDR_W-1:0] laddr);
      int lsu_start;
      int fetch_start;
      lsu_start   = lsu_done_cnt;
      fetch_start = fetch_done_cnt;
      fetch_base_q.push_back(faddr & ~ADDR_W'(LINE_BYTES - 1));
      lsu_addr_q.push_back(laddr);
      lsu_load_q.push_back(1'b1);
      @(posedge clk);
      fetch_req  <= 1'b1;
      fetch_addr <= faddr;
      lsu_req    <= 1'b1;
      lsu_op     <= LSU_LOAD;
      lsu_addr   <= laddr;
      @(posedge clk);
      fetch_req <= 1'b0;
      lsu_req   <= 1'b0;
      @(negedge clk);
      check_busy("fetch_busy", fetch_busy, 1'b1);
      check_busy("lsu_busy", lsu_busy, 1'b1);
      while (lsu_done_cnt == lsu_start || fetch_done_cnt == fetch_start) @(posedge clk);
      @(negedge clk);
      check_busy("fetch_busy", fetch_busy, 1'b0);
      check_busy("lsu_busy", lsu_busy, 1'b0);
      checks++;
      if (!(fetch_done_cyc < lsu_done_cyc)) begin
         $display("%s: fetch_done at cycle %0d did not come before lsu_done at cycle %0d",
                  cur_test, fetch_done_cyc, lsu_done_cyc);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == test_errs) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", cur_test, errors - test_errs);
      end
   endtask

   initial begin : stimulus
      int unsigned       idx;
      int                i;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic [ADDR_W-1:0] addr;
      rst        = 1'b1;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      lsu_req    = 1'b0;
      lsu_op     = LSU_LOAD;
      lsu_addr   = '0;
      lsu_wdata  = '0;
      lsu_wstrb  = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // every region word gets a known value first
      start_test("mem_fill");
      for (i = 0; i < REGION_WORDS; i++) begin
         data = {$random(seed), $random(seed)};
         issue_store(ADDR_W'(i * 8), data, '1);
      end
      end_test();

      start_test("store_load");
      for (i = 0; i < 64; i++) begin
         idx  = $random(seed) & (REGION_WORDS - 1);
         addr = ADDR_W'(idx * 8);
         data = {$random(seed), $random(seed)};
         issue_store(addr, data, '1);
         issue_load(addr);
      end
      end_test();

      start_test("byte_strobe");
      for (i = 0; i < 16; i++) begin
         idx  = $random(seed) & (REGION_WORDS - 1);
         addr = ADDR_W'(idx * 8);
         data = {$random(seed), $random(seed)};
         strb = STRB_W'($random(seed));
         issue_store(addr, data, strb);
         issue_load(addr);
      end
      end_test();

      // byte address anywhere in a line, base comes from alignment
      start_test("line_fetch");
      for (i = 0; i < 16; i++) begin
         addr = ADDR_W'($random(seed) & (REGION_WORDS * 8 - 1));
         issue_fetch(addr);
      end
      end_test();

      start_test("simultaneous");
      for (i = 0; i < 4; i++) begin
         addr = ADDR_W'($random(seed) & (REGION_WORDS * 8 - 1));
         idx  = $random(seed) & (REGION_WORDS - 1);
         issue_both(addr, ADDR_W'(idx * 8));
      end
      end_test();

      start_test("out_of_range");
      issue_load(ADDR_W'(OOR_BASE + ($random(seed) & 32'h0000_fff8)));
      issue_fetch(ADDR_W'(OOR_BASE + ($random(seed) & 32'h0000_ffe0)));
      // low index bits land on a filled word
      idx = $random(seed) & (REGION_WORDS - 1);
      issue_store(ADDR_W'(OOR_BASE + idx * 8), {$random(seed), $random(seed)}, '1);
      // whole region read back by lines
      for (i = 0; i < REGION_WORDS * 8 / LINE_BYTES; i++) begin
         issue_fetch(ADDR_W'(i * LINE_BYTES));
      end
      end_test();

      $display("%0d tests run, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_bad, checks, errors);
      if (errors == 0 && tests_bad == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* list.f */
hdl/axi_pkg.sv
hdl/lsu_pkg.sv
hdl/axi_if.sv
hdl/axi_arbiter.sv
hdl/fetch_master.sv
hdl/lsu_master.sv
hdl/axi_sram.sv
hdl/mem_subsys_top.sv
sim/mem_subsys_sva.sv
sim/tb_mem_subsys.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mem_subsys
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = all tests passed
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
